// ==== logic/dsp_sat.sv ====
`timescale 1ns/1ps

module dsp_sat (
  input  logic                              clk,
  input  logic                              arst_n_i,
  input  logic                              enable_i,
  input  logic [dsp_sat_cfg_pkg::IN_W-1:0]  idata_i,
  input  dsp_sat_op_pkg::dfmt_e             dform_i,
  input  dsp_sat_op_pkg::sat_type_e         type_i,
  input  logic                              signed_i,
  output logic                              valid_o,
  output logic [dsp_sat_cfg_pkg::RES_W-1:0] result_o,
  output logic                              ov_o
);

  dsp_sat_op_pkg::sat_mode_e         mode;
  logic [dsp_sat_cfg_pkg::RES_W-1:0] byte_res;
  logic [dsp_sat_cfg_pkg::RES_W-1:0] half_res;
  logic [dsp_sat_cfg_pkg::RES_W-1:0] word_res;
  logic                              byte_ov;
  logic                              half_ov;
  logic                              word_ov;

  dsp_sat_decode i_decode (
    .type_i   (type_i),
    .dform_i  (dform_i),
    .signed_i (signed_i),
    .mode_o   (mode)
  );

  // At most one lane module is active for a given mode. The others give zero.
  dsp_sat_byte i_byte (
    .mode_i (mode),
    .sum_i  (idata_i),
    .res_o  (byte_res),
    .ov_o   (byte_ov)
  );

  dsp_sat_half i_half (
    .mode_i (mode),
    .sum_i  (idata_i),
    .res_o  (half_res),
    .ov_o   (half_ov)
  );

  dsp_sat_word i_word (
    .mode_i (mode),
    .sum_i  (idata_i),
    .res_o  (word_res),
    .ov_o   (word_ov)
  );

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      ov_o     <= 1'b0;
    end else begin
      valid_o <= enable_i;
      if (enable_i) begin
        result_o <= byte_res | half_res | word_res;
        ov_o     <= byte_ov | half_ov | word_ov;
      end
    end
  end

endmodule

// ==== logic/dsp_sat_byte.sv ====
`timescale 1ns/1ps

module dsp_sat_byte (
  input  dsp_sat_op_pkg::sat_mode_e         mode_i,
  input  logic [dsp_sat_cfg_pkg::IN_W-1:0]  sum_i,
  output logic [dsp_sat_cfg_pkg::RES_W-1:0] res_o,
  output logic                              ov_o
);

  logic [dsp_sat_cfg_pkg::BYTE_LANES-1:0] lane_ov;

  for (genvar k = 0; k < dsp_sat_cfg_pkg::BYTE_LANES; k++) begin : g_lane
    logic [dsp_sat_cfg_pkg::BYTE_W-1:0] d;
    logic [dsp_sat_cfg_pkg::BYTE_W-1:0] r;
    logic                               g;
    logic                               m;
    logic                               o;

    assign d = sum_i[k*dsp_sat_cfg_pkg::BYTE_STRIDE +: dsp_sat_cfg_pkg::BYTE_W];
    assign g = sum_i[k*dsp_sat_cfg_pkg::BYTE_STRIDE + dsp_sat_cfg_pkg::BYTE_W];
    assign m = d[dsp_sat_cfg_pkg::BYTE_W-1];

    always_comb begin
      r = '0;
      o = 1'b0;
      case (mode_i)
        dsp_sat_op_pkg::MODE_Q7B: begin
          if (!g && m) begin
            r = {1'b0, {(dsp_sat_cfg_pkg::BYTE_W-1){1'b1}}};
            o = 1'b1;
          end else if (g && !m) begin
            r = {1'b1, {(dsp_sat_cfg_pkg::BYTE_W-1){1'b0}}};
            o = 1'b1;
          end else begin
            r = d;
          end
        end
        dsp_sat_op_pkg::MODE_U8B_S: begin
          r = g ? '0 : d;
          o = g;
        end
        dsp_sat_op_pkg::MODE_U8B_U: begin
          r = g ? '1 : d;
          o = g;
        end
        dsp_sat_op_pkg::MODE_ABSB: begin
          // A negative lane comes in already negated except for the final +1.
          case ({g, m})
            2'b10: begin
              r = {1'b0, {(dsp_sat_cfg_pkg::BYTE_W-1){1'b1}}};
              o = 1'b1;
            end
            2'b11:   r = ~d;
            2'b00:   r = d;
            default: r = '0;
          endcase
        end
        default: begin
          r = '0;
          o = 1'b0;
        end
      endcase
    end

    assign res_o[k*dsp_sat_cfg_pkg::BYTE_W +: dsp_sat_cfg_pkg::BYTE_W] = r;
    assign lane_ov[k] = o;
  end

  assign ov_o = |lane_ov;

endmodule

// ==== logic/dsp_sat_cfg_pkg.sv ====
package dsp_sat_cfg_pkg;

  // Raw adder sum. Each lane carries one guard bit above its data bits.
  localparam int unsigned IN_W = 39;

  // Clipped result width.
  localparam int unsigned RES_W = 32;

  // Byte lane k has data at 10k+7..10k and its guard bit at 10k+8.
  localparam int unsigned BYTE_STRIDE = 10;
  localparam int unsigned BYTE_W = 8;
  localparam int unsigned BYTE_LANES = 4;

  // Halfword lanes have data at base+15..base and the guard bit at base+16.
  localparam int unsigned HALF_LO_BASE = 0;
  localparam int unsigned HALF_HI_BASE = 20;
  localparam int unsigned HALF_W = 16;
  localparam int unsigned HALF_LANES = 2;

  // The word lane uses bits 31..0 with its guard bit at 32.
  localparam int unsigned WORD_GUARD = 32;

endpackage

// ==== logic/dsp_sat_decode.sv ====
`timescale 1ns/1ps

module dsp_sat_decode (
  input  dsp_sat_op_pkg::sat_type_e type_i,
  input  dsp_sat_op_pkg::dfmt_e     dform_i,
  input  logic                      signed_i,
  output dsp_sat_op_pkg::sat_mode_e mode_o
);

  always_comb begin
    mode_o = dsp_sat_op_pkg::MODE_NONE;
    case (dform_i)
      dsp_sat_op_pkg::DFMT_B8: begin
        case (type_i)
          dsp_sat_op_pkg::SAT_Q: begin
            if (signed_i) mode_o = dsp_sat_op_pkg::MODE_Q7B;
          end
          dsp_sat_op_pkg::SAT_U8: begin
            mode_o = signed_i ? dsp_sat_op_pkg::MODE_U8B_S : dsp_sat_op_pkg::MODE_U8B_U;
          end
          dsp_sat_op_pkg::SAT_ABS: mode_o = dsp_sat_op_pkg::MODE_ABSB;
          default: mode_o = dsp_sat_op_pkg::MODE_NONE;
        endcase
      end
      dsp_sat_op_pkg::DFMT_H16: begin
        case (type_i)
          dsp_sat_op_pkg::SAT_Q15: begin
            if (signed_i) mode_o = dsp_sat_op_pkg::MODE_Q15H;
          end
          dsp_sat_op_pkg::SAT_U16: begin
            mode_o = signed_i ? dsp_sat_op_pkg::MODE_U16H_S : dsp_sat_op_pkg::MODE_U16H_U;
          end
          dsp_sat_op_pkg::SAT_ABS:  mode_o = dsp_sat_op_pkg::MODE_ABSH;
          dsp_sat_op_pkg::SAT_UXAS: mode_o = dsp_sat_op_pkg::MODE_UXAS;
          dsp_sat_op_pkg::SAT_UXSA: mode_o = dsp_sat_op_pkg::MODE_UXSA;
          default: mode_o = dsp_sat_op_pkg::MODE_NONE;
        endcase
      end
      dsp_sat_op_pkg::DFMT_W32: begin
        case (type_i)
          dsp_sat_op_pkg::SAT_Q15: begin
            if (signed_i) mode_o = dsp_sat_op_pkg::MODE_Q15W;
          end
          dsp_sat_op_pkg::SAT_Q31: begin
            if (signed_i) mode_o = dsp_sat_op_pkg::MODE_Q31W;
          end
          dsp_sat_op_pkg::SAT_U16: begin
            mode_o = signed_i ? dsp_sat_op_pkg::MODE_U16W_S : dsp_sat_op_pkg::MODE_U16W_U;
          end
          dsp_sat_op_pkg::SAT_U32: begin
            mode_o = signed_i ? dsp_sat_op_pkg::MODE_U32W_S : dsp_sat_op_pkg::MODE_U32W_U;
          end
          dsp_sat_op_pkg::SAT_ABS: mode_o = dsp_sat_op_pkg::MODE_ABSW;
          default: mode_o = dsp_sat_op_pkg::MODE_NONE;
        endcase
      end
      // The 64-bit format has no datapath here.
      default: mode_o = dsp_sat_op_pkg::MODE_NONE;
    endcase
  end

endmodule

// ==== logic/dsp_sat_half.sv ====
`timescale 1ns/1ps

module dsp_sat_half (
  input  dsp_sat_op_pkg::sat_mode_e         mode_i,
  input  logic [dsp_sat_cfg_pkg::IN_W-1:0]  sum_i,
  output logic [dsp_sat_cfg_pkg::RES_W-1:0] res_o,
  output logic                              ov_o
);

  logic [dsp_sat_cfg_pkg::HALF_LANES-1:0] lane_ov;

  for (genvar k = 0; k < dsp_sat_cfg_pkg::HALF_LANES; k++) begin : g_lane
    logic [dsp_sat_cfg_pkg::HALF_W-1:0] d;
    logic [dsp_sat_cfg_pkg::HALF_W-1:0] r;
    logic                               g;
    logic                               m;
    logic                               o;

    // Lane 1 is the upper halfword of the result.
    assign {g, d} = (k == 0) ?
        sum_i[dsp_sat_cfg_pkg::HALF_LO_BASE +: dsp_sat_cfg_pkg::HALF_W+1] :
        sum_i[dsp_sat_cfg_pkg::HALF_HI_BASE +: dsp_sat_cfg_pkg::HALF_W+1];
    assign m = d[dsp_sat_cfg_pkg::HALF_W-1];

    always_comb begin
      r = '0;
      o = 1'b0;
      case (mode_i)
        dsp_sat_op_pkg::MODE_Q15H: begin
          if (!g && m) begin
            r = {1'b0, {(dsp_sat_cfg_pkg::HALF_W-1){1'b1}}};
            o = 1'b1;
          end else if (g && !m) begin
            r = {1'b1, {(dsp_sat_cfg_pkg::HALF_W-1){1'b0}}};
            o = 1'b1;
          end else begin
            r = d;
          end
        end
        dsp_sat_op_pkg::MODE_U16H_S: begin
          r = g ? '0 : d;
          o = g;
        end
        dsp_sat_op_pkg::MODE_U16H_U: begin
          r = g ? '1 : d;
          o = g;
        end
        dsp_sat_op_pkg::MODE_UXAS: begin
          r = (k == 1) ? (g ? '1 : d) : (g ? '0 : d);
          o = g;
        end
        dsp_sat_op_pkg::MODE_UXSA: begin
          r = (k == 1) ? (g ? '0 : d) : (g ? '1 : d);
          o = g;
        end
        dsp_sat_op_pkg::MODE_ABSH: begin
          case ({g, m})
            2'b10: begin
              r = {1'b0, {(dsp_sat_cfg_pkg::HALF_W-1){1'b1}}};
              o = 1'b1;
            end
            2'b11:   r = ~d;
            2'b00:   r = d;
            default: r = '0;
          endcase
        end
        default: begin
          r = '0;
          o = 1'b0;
        end
      endcase
    end

    assign res_o[k*dsp_sat_cfg_pkg::HALF_W +: dsp_sat_cfg_pkg::HALF_W] = r;
    assign lane_ov[k] = o;
  end

  assign ov_o = |lane_ov;

endmodule

// ==== logic/dsp_sat_op_pkg.sv ====
package dsp_sat_op_pkg;

  // Destination data format. DFMT_D64 is not supported by this unit.
  typedef enum logic [2:0] {
    DFMT_B8  = 3'd0,
    DFMT_H16 = 3'd1,
    DFMT_W32 = 3'd2,
    DFMT_D64 = 3'd3
  } dfmt_e;

  // Saturation type as issued by the core. Codes 9 and 10 are not handled.
  typedef enum logic [3:0] {
    SAT_Q    = 4'd0,
    SAT_U8   = 4'd1,
    SAT_Q15  = 4'd2,
    SAT_U16  = 4'd3,
    SAT_Q31  = 4'd4,
    SAT_U32  = 4'd5,
    SAT_ABS  = 4'd6,
    SAT_UXAS = 4'd7,
    SAT_UXSA = 4'd8
  } sat_type_e;

  // Decoded mode. The _S and _U suffixes give the signedness of the sum.
  typedef enum logic [4:0] {
    MODE_NONE,
    MODE_Q7B,
    MODE_U8B_S,
    MODE_U8B_U,
    MODE_ABSB,
    MODE_Q15H,
    MODE_U16H_S,
    MODE_U16H_U,
    MODE_ABSH,
    MODE_UXAS,
    MODE_UXSA,
    MODE_Q15W,
    MODE_U16W_S,
    MODE_U16W_U,
    MODE_Q31W,
    MODE_U32W_S,
    MODE_U32W_U,
    MODE_ABSW
  } sat_mode_e;

endpackage

// ==== logic/dsp_sat_word.sv ====
`timescale 1ns/1ps

module dsp_sat_word (
  input  dsp_sat_op_pkg::sat_mode_e         mode_i,
  input  logic [dsp_sat_cfg_pkg::IN_W-1:0]  sum_i,
  output logic [dsp_sat_cfg_pkg::RES_W-1:0] res_o,
  output logic                              ov_o
);

  logic [dsp_sat_cfg_pkg::RES_W-1:0] d;
  logic                              g;
  logic                              m;
  logic                              q15_pos;
  logic                              q15_neg;
  logic                              hi_set;

  assign d = sum_i[dsp_sat_cfg_pkg::RES_W-1:0];
  assign g = sum_i[dsp_sat_cfg_pkg::WORD_GUARD];
  assign m = d[dsp_sat_cfg_pkg::RES_W-1];

  // Bits 31..15 must all equal the guard bit for the lane to fit in Q15.
  assign q15_pos = !g && (|d[dsp_sat_cfg_pkg::RES_W-1:dsp_sat_cfg_pkg::HALF_W-1]);
  assign q15_neg = g && !(&d[dsp_sat_cfg_pkg::RES_W-1:dsp_sat_cfg_pkg::HALF_W-1]);
  assign hi_set  = |d[dsp_sat_cfg_pkg::RES_W-1:dsp_sat_cfg_pkg::HALF_W];

  always_comb begin
    res_o = '0;
    ov_o  = 1'b0;
    case (mode_i)
      dsp_sat_op_pkg::MODE_Q15W: begin
        ov_o = q15_pos || q15_neg;
        if (q15_pos) begin
          res_o = {{(dsp_sat_cfg_pkg::RES_W-dsp_sat_cfg_pkg::HALF_W+1){1'b0}},
                   {(dsp_sat_cfg_pkg::HALF_W-1){1'b1}}};
        end else if (q15_neg) begin
          res_o = {{(dsp_sat_cfg_pkg::RES_W-dsp_sat_cfg_pkg::HALF_W+1){1'b1}},
                   {(dsp_sat_cfg_pkg::HALF_W-1){1'b0}}};
        end else begin
          res_o = {{(dsp_sat_cfg_pkg::RES_W-dsp_sat_cfg_pkg::HALF_W){g}},
                   d[dsp_sat_cfg_pkg::HALF_W-1:0]};
        end
      end
      dsp_sat_op_pkg::MODE_U16W_S, dsp_sat_op_pkg::MODE_U16W_U: begin
        ov_o = g || hi_set;
        // Only the signed variant treats a set guard bit as a negative value.
        if (g && mode_i == dsp_sat_op_pkg::MODE_U16W_S) begin
          res_o = '0;
        end else if (ov_o) begin
          res_o = {{(dsp_sat_cfg_pkg::RES_W-dsp_sat_cfg_pkg::HALF_W){1'b0}},
                   {dsp_sat_cfg_pkg::HALF_W{1'b1}}};
        end else begin
          res_o = {{(dsp_sat_cfg_pkg::RES_W-dsp_sat_cfg_pkg::HALF_W){1'b0}},
                   d[dsp_sat_cfg_pkg::HALF_W-1:0]};
        end
      end
      dsp_sat_op_pkg::MODE_Q31W: begin
        ov_o = g ^ m;
        if (!g && m) res_o = {1'b0, {(dsp_sat_cfg_pkg::RES_W-1){1'b1}}};
        else if (g && !m) res_o = {1'b1, {(dsp_sat_cfg_pkg::RES_W-1){1'b0}}};
        else res_o = d;
      end
      dsp_sat_op_pkg::MODE_U32W_S: begin
        res_o = g ? '0 : d;
        ov_o  = g;
      end
      dsp_sat_op_pkg::MODE_U32W_U: begin
        res_o = g ? '1 : d;
        ov_o  = g;
      end
      dsp_sat_op_pkg::MODE_ABSW: begin
        ov_o = g && !m;
        case ({g, m})
          2'b10:   res_o = {1'b0, {(dsp_sat_cfg_pkg::RES_W-1){1'b1}}};
          2'b11:   res_o = ~d;
          2'b00:   res_o = d;
          default: res_o = '0;
        endcase
      end
      default: begin
        res_o = '0;
        ov_o  = 1'b0;
      end
    endcase
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary -f src.f --top-module dsp_sat_tb --Mdir obj_dir -o dsp_sat_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status."
  exit 1
fi

./obj_dir/dsp_sat_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log."
exit 1

// ==== src.f ====
+incdir+include
logic/dsp_sat_cfg_pkg.sv
logic/dsp_sat_op_pkg.sv
logic/dsp_sat_decode.sv
logic/dsp_sat_byte.sv
logic/dsp_sat_half.sv
logic/dsp_sat_word.sv
logic/dsp_sat.sv
tb/dsp_sat_tb.sv

// ==== include/dsp_sat_model.svh ====
`ifndef DSP_SAT_MODEL_SVH
`define DSP_SAT_MODEL_SVH

// Clips one n-bit lane held in the low n+1 bits of lane. Returns {flag, result}.
// Kind is "s" signed, "z" signed to unsigned, "u" unsigned or "a" absolute value.
function automatic logic [32:0] clip_lane(input logic [32:0] lane, input int n,
                                          input byte kind);
  logic [31:0] mask;
  logic [31:0] d;
  logic [31:0] max_p;
  logic        g;
  logic        m;

  mask  = 32'hffff_ffff >> (32 - n);
  d     = lane[31:0] & mask;
  max_p = mask >> 1;
  g     = lane[n];
  m     = lane[n-1];
  case (kind)
    "s": begin
      if (!g && m) return {1'b1, max_p};
      if (g && !m) return {1'b1, mask & ~max_p};
      return {1'b0, d};
    end
    "z": return g ? {1'b1, 32'h0} : {1'b0, d};
    "u": return g ? {1'b1, mask} : {1'b0, d};
    "a": begin
      case ({g, m})
        2'b10:   return {1'b1, max_p};
        2'b11:   return {1'b0, ~d & mask};
        2'b00:   return {1'b0, d};
        default: return 33'h0;
      endcase
    end
    default: return 33'h0;
  endcase
endfunction

function automatic void dsp_sat_model(
  input  logic [dsp_sat_cfg_pkg::IN_W-1:0] sum,
  input  dsp_sat_op_pkg::dfmt_e            dform,
  input  dsp_sat_op_pkg::sat_type_e        typ,
  input  logic                             sgn,
  output logic [31:0]                      res,
  output logic                             ov
);
  byte                kind_lo;
  byte                kind_hi;
  logic [32:0]        r;
  logic signed [32:0] v;

  kind_lo = 0;
  kind_hi = 0;
  res     = '0;
  ov      = 1'b0;
  v       = $signed(sum[32:0]);
  case (dform)
    dsp_sat_op_pkg::DFMT_B8: begin
      case (typ)
        dsp_sat_op_pkg::SAT_Q:   kind_lo = sgn ? "s" : 0;
        dsp_sat_op_pkg::SAT_U8:  kind_lo = sgn ? "z" : "u";
        dsp_sat_op_pkg::SAT_ABS: kind_lo = "a";
        default:                 kind_lo = 0;
      endcase
      for (int k = 0; k < 4 && kind_lo != 0; k++) begin
        r = clip_lane(33'(sum[k*dsp_sat_cfg_pkg::BYTE_STRIDE +: 9]), 8, kind_lo);
        res[8*k +: 8] = r[7:0];
        ov = ov | r[32];
      end
    end
    dsp_sat_op_pkg::DFMT_H16: begin
      case (typ)
        dsp_sat_op_pkg::SAT_Q15:  kind_lo = sgn ? "s" : 0;
        dsp_sat_op_pkg::SAT_U16:  kind_lo = sgn ? "z" : "u";
        dsp_sat_op_pkg::SAT_ABS:  kind_lo = "a";
        dsp_sat_op_pkg::SAT_UXAS: kind_lo = "z";
        dsp_sat_op_pkg::SAT_UXSA: kind_lo = "u";
        default:                  kind_lo = 0;
      endcase
      kind_hi = (typ == dsp_sat_op_pkg::SAT_UXAS) ? "u" :
                (typ == dsp_sat_op_pkg::SAT_UXSA) ? "z" : kind_lo;
      if (kind_lo != 0) begin
        r = clip_lane(33'(sum[dsp_sat_cfg_pkg::HALF_LO_BASE +: 17]), 16, kind_lo);
        res[15:0] = r[15:0];
        ov = r[32];
        r = clip_lane(33'(sum[dsp_sat_cfg_pkg::HALF_HI_BASE +: 17]), 16, kind_hi);
        res[31:16] = r[15:0];
        ov = ov | r[32];
      end
    end
    dsp_sat_op_pkg::DFMT_W32: begin
      case (typ)
        dsp_sat_op_pkg::SAT_Q15: begin
          if (sgn) begin
            ov  = (v > 32767) || (v < -32768);
            res = (v > 32767) ? 32'h0000_7fff : (v < -32768) ? 32'hffff_8000 : v[31:0];
          end
        end
        dsp_sat_op_pkg::SAT_U16: begin
          ov  = sgn ? ((v < 0) || (v > 65535)) : (sum[32:16] != 0);
          res = (sgn && v < 0) ? 32'h0 : ov ? 32'h0000_ffff : {16'h0, sum[15:0]};
        end
        dsp_sat_op_pkg::SAT_Q31: kind_lo = sgn ? "s" : 0;
        dsp_sat_op_pkg::SAT_U32: kind_lo = sgn ? "z" : "u";
        dsp_sat_op_pkg::SAT_ABS: kind_lo = "a";
        default:                 kind_lo = 0;
      endcase
      if (kind_lo != 0) begin
        r   = clip_lane(sum[32:0], 32, kind_lo);
        res = r[31:0];
        ov  = r[32];
      end
    end
    default: res = '0;
  endcase
endfunction

`endif

// ==== tb/dsp_sat_tb.sv ====
`timescale 1ns/1ps

module dsp_sat_tb;

  // The stimulus takes roughly 3000 cycles, most of it in the random test.
  localparam int TIMEOUT_CYCLES = 6000;

  logic                              clk;
  logic                              arst_n_i;
  logic                              enable_i;
  logic [dsp_sat_cfg_pkg::IN_W-1:0]  idata_i;
  dsp_sat_op_pkg::dfmt_e             dform_i;
  dsp_sat_op_pkg::sat_type_e         type_i;
  logic                              signed_i;
  logic                              valid_o;
  logic [dsp_sat_cfg_pkg::RES_W-1:0] result_o;
  logic                              ov_o;

  // Expected {flag, result} in issue order.
  logic [32:0] exp_q[$];
  logic [32:0] last_exp = '0;
  logic        en_d;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  `include "dsp_sat_model.svh"

  dsp_sat i_dsp_sat (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .enable_i (enable_i),
    .idata_i  (idata_i),
    .dform_i  (dform_i),
    .type_i   (type_i),
    .signed_i (signed_i),
    .valid_o  (valid_o),
    .result_o (result_o),
    .ov_o     (ov_o)
  );

  always #4 clk = ~clk;

  // valid_o must follow enable_i with exactly one cycle of delay.
  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) en_d <= 1'b0;
    else en_d <= enable_i;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("The run timed out after %0d cycles.", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // Outputs are sampled on the falling edge, half a cycle away from any change.
  always @(negedge clk) begin : compare
    logic [32:0] e;
    if (!arst_n_i) begin
      check("valid_o", 32'(valid_o), 32'h0);
      check("result_o", result_o, 32'h0);
      check("ov_o", 32'(ov_o), 32'h0);
    end else begin
      check("valid_o", 32'(valid_o), 32'(en_d));
      if (valid_o && exp_q.size() == 0) begin
        $display("valid_o was high with no result pending.");
        errors++;
      end else if (valid_o) begin
        e = exp_q.pop_front();
        check("result_o", result_o, e[31:0]);
        check("ov_o", 32'(ov_o), 32'(e[32]));
        last_exp = e;
      end else begin
        check("result_o", result_o, last_exp[31:0]);
        check("ov_o", 32'(ov_o), 32'(last_exp[32]));
      end
    end
  end

  function automatic logic [38:0] rand_sum();
    logic [63:0] w;
    w = {$urandom(), $urandom()};
    return w[38:0];
  endfunction

  function automatic logic [38:0] pack_bytes(input logic [8:0] l3, input logic [8:0] l2,
                                             input logic [8:0] l1, input logic [8:0] l0);
    return {l3, 1'b0, l2, 1'b0, l1, 1'b0, l0};
  endfunction

  function automatic logic [38:0] pack_halves(input logic [16:0] hi, input logic [16:0] lo);
    return {2'b00, hi, 3'b000, lo};
  endfunction

  task automatic issue(input logic [38:0] sum, input dsp_sat_op_pkg::dfmt_e f,
                       input dsp_sat_op_pkg::sat_type_e t, input logic s);
    logic [31:0] res;
    logic        ov;
    @(posedge clk);
    #1;
    enable_i = 1'b1;
    idata_i  = sum;
    dform_i  = f;
    type_i   = t;
    signed_i = s;
    dsp_sat_model(sum, f, t, s, res, ov);
    exp_q.push_back({ov, res});
  endtask

  // Random data with enable low must not disturb the held result.
  task automatic idle();
    @(posedge clk);
    #1;
    enable_i = 1'b0;
    idata_i  = rand_sum();
  endtask

  task automatic drain();
    idle();
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic report(input string name, input int e0);
    if (errors == e0) $display("test %-12s ok", name);
    else $display("test %-12s %0d errors", name, errors - e0);
  endtask

  task automatic byte_edges();
    logic [8:0]                edges[4];
    dsp_sat_op_pkg::sat_type_e types[4];
    logic                      sgns[4];
    edges = '{9'h005, 9'h080, 9'h17f, 9'h181};
    types = '{dsp_sat_op_pkg::SAT_Q, dsp_sat_op_pkg::SAT_U8, dsp_sat_op_pkg::SAT_U8,
              dsp_sat_op_pkg::SAT_ABS};
    sgns  = '{1'b1, 1'b1, 1'b0, 1'b1};
    for (int m = 0; m < 4; m++) begin
      for (int r = 0; r < 4; r++) begin
        issue(pack_bytes(edges[(r+3)%4], edges[(r+2)%4], edges[(r+1)%4], edges[r]),
              dsp_sat_op_pkg::DFMT_B8, types[m], sgns[m]);
      end
      issue(pack_bytes(9'h005, 9'h07f, 9'h1ff, 9'h010), dsp_sat_op_pkg::DFMT_B8,
            types[m], sgns[m]);
    end
    drain();
  endtask

  task automatic half_pairs();
    logic [16:0]               edges[4];
    dsp_sat_op_pkg::sat_type_e types[6];
    logic                      sgns[6];
    edges = '{17'h0_1234, 17'h0_8000, 17'h1_7fff, 17'h1_8001};
    types = '{dsp_sat_op_pkg::SAT_Q15, dsp_sat_op_pkg::SAT_U16, dsp_sat_op_pkg::SAT_U16,
              dsp_sat_op_pkg::SAT_ABS, dsp_sat_op_pkg::SAT_UXAS, dsp_sat_op_pkg::SAT_UXSA};
    sgns  = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
    // All lane pairs, so some operations clip in one lane only.
    for (int m = 0; m < 6; m++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          issue(pack_halves(edges[i], edges[j]), dsp_sat_op_pkg::DFMT_H16, types[m], sgns[m]);
        end
      end
    end
    drain();
  endtask

  task automatic word_edges();
    logic [32:0]               edges[12];
    dsp_sat_op_pkg::sat_type_e types[7];
    logic                      sgns[7];
    edges = '{33'h0_0000_1234, 33'h0_0000_7fff, 33'h0_0000_8000, 33'h0_0001_0000,
              33'h0_0000_ffff, 33'h1_ffff_8000, 33'h1_ffff_7fff, 33'h1_ffff_ffff,
              33'h0_8000_0000, 33'h1_7fff_ffff, 33'h1_8000_0001, 33'h0_7fff_ffff};
    types = '{dsp_sat_op_pkg::SAT_Q15, dsp_sat_op_pkg::SAT_U16, dsp_sat_op_pkg::SAT_U16,
              dsp_sat_op_pkg::SAT_Q31, dsp_sat_op_pkg::SAT_U32, dsp_sat_op_pkg::SAT_U32,
              dsp_sat_op_pkg::SAT_ABS};
    sgns  = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
    for (int m = 0; m < 7; m++) begin
      for (int i = 0; i < 12; i++) begin
        issue({6'($urandom_range(63)), edges[i]}, dsp_sat_op_pkg::DFMT_W32, types[m], sgns[m]);
      end
    end
    drain();
  endtask

  task automatic unsupported_codes();
    for (int t = 0; t < 11; t++) begin
      issue(rand_sum(), dsp_sat_op_pkg::DFMT_D64, dsp_sat_op_pkg::sat_type_e'(4'(t)), 1'b1);
      issue(rand_sum(), dsp_sat_op_pkg::DFMT_D64, dsp_sat_op_pkg::sat_type_e'(4'(t)), 1'b0);
    end
    for (int f = 0; f < 3; f++) begin
      for (int t = 9; t < 11; t++) begin
        issue(rand_sum(), dsp_sat_op_pkg::dfmt_e'(3'(f)), dsp_sat_op_pkg::sat_type_e'(4'(t)),
              1'b1);
        issue(rand_sum(), dsp_sat_op_pkg::dfmt_e'(3'(f)), dsp_sat_op_pkg::sat_type_e'(4'(t)),
              1'b0);
      end
      issue(rand_sum(), dsp_sat_op_pkg::dfmt_e'(3'(f)), dsp_sat_op_pkg::SAT_Q, 1'b0);
      issue(rand_sum(), dsp_sat_op_pkg::dfmt_e'(3'(f)), dsp_sat_op_pkg::SAT_Q15, 1'b0);
      issue(rand_sum(), dsp_sat_op_pkg::dfmt_e'(3'(f)), dsp_sat_op_pkg::SAT_Q31, 1'b0);
    end
    drain();
  endtask

  task automatic random_traffic();
    dsp_sat_op_pkg::dfmt_e     fl[17];
    dsp_sat_op_pkg::sat_type_e tl[17];
    logic                      sl[17];
    int                        k;
    fl = '{dsp_sat_op_pkg::DFMT_B8, dsp_sat_op_pkg::DFMT_B8, dsp_sat_op_pkg::DFMT_B8,
           dsp_sat_op_pkg::DFMT_B8, dsp_sat_op_pkg::DFMT_H16, dsp_sat_op_pkg::DFMT_H16,
           dsp_sat_op_pkg::DFMT_H16, dsp_sat_op_pkg::DFMT_H16, dsp_sat_op_pkg::DFMT_H16,
           dsp_sat_op_pkg::DFMT_H16, dsp_sat_op_pkg::DFMT_W32, dsp_sat_op_pkg::DFMT_W32,
           dsp_sat_op_pkg::DFMT_W32, dsp_sat_op_pkg::DFMT_W32, dsp_sat_op_pkg::DFMT_W32,
           dsp_sat_op_pkg::DFMT_W32, dsp_sat_op_pkg::DFMT_W32};
    tl = '{dsp_sat_op_pkg::SAT_Q, dsp_sat_op_pkg::SAT_U8, dsp_sat_op_pkg::SAT_U8,
           dsp_sat_op_pkg::SAT_ABS, dsp_sat_op_pkg::SAT_Q15, dsp_sat_op_pkg::SAT_U16,
           dsp_sat_op_pkg::SAT_U16, dsp_sat_op_pkg::SAT_ABS, dsp_sat_op_pkg::SAT_UXAS,
           dsp_sat_op_pkg::SAT_UXSA, dsp_sat_op_pkg::SAT_Q15, dsp_sat_op_pkg::SAT_U16,
           dsp_sat_op_pkg::SAT_U16, dsp_sat_op_pkg::SAT_Q31, dsp_sat_op_pkg::SAT_U32,
           dsp_sat_op_pkg::SAT_U32, dsp_sat_op_pkg::SAT_ABS};
    sl = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0,
           1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
    for (int i = 0; i < 2000; i++) begin
      if ($urandom_range(3) == 0) idle();
      k = int'($urandom_range(16));
      issue(rand_sum(), fl[k], tl[k], sl[k]);
    end
    drain();
  endtask

  initial begin
    int e0;
    void'($urandom(32'hb303ba5d));
    clk      = 1'b0;
    arst_n_i = 1'b1;
    enable_i = 1'b0;
    idata_i  = '0;
    dform_i  = dsp_sat_op_pkg::DFMT_B8;
    type_i   = dsp_sat_op_pkg::SAT_Q;
    signed_i = 1'b0;
    // Enable is high through reset, and the outputs must still stay at zero.
    #1;
    arst_n_i = 1'b0;
    enable_i = 1'b1;
    idata_i  = rand_sum();
    repeat (4) @(posedge clk);
    #1;
    arst_n_i = 1'b1;
    enable_i = 1'b0;

    e0 = errors;
    issue(pack_bytes(9'h005, 9'h080, 9'h17f, 9'h181), dsp_sat_op_pkg::DFMT_B8,
          dsp_sat_op_pkg::SAT_Q, 1'b1);
    idle();
    issue(rand_sum(), dsp_sat_op_pkg::DFMT_W32, dsp_sat_op_pkg::SAT_Q31, 1'b1);
    issue(rand_sum(), dsp_sat_op_pkg::DFMT_H16, dsp_sat_op_pkg::SAT_ABS, 1'b0);
    idle();
    drain();
    report("reset_latency", e0);
    e0 = errors;
    byte_edges();
    report("byte_modes", e0);
    e0 = errors;
    half_pairs();
    report("half_modes", e0);
    e0 = errors;
    word_edges();
    report("word_modes", e0);
    e0 = errors;
    unsupported_codes();
    report("unsupported", e0);
    e0 = errors;
    random_traffic();
    report("random", e0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
